// ==== hw/controlStore.sv ====
`timescale 1ns/10ps

module controlStore
#(
   parameter int addrWidth = useqPkg::addrWidth,
   parameter int payloadWidth = useqPkg::payloadWidth
)
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 clken,
   input  logic [addrWidth-1:0] nextAddr,
   output logic [addrWidth+useqPkg::cromCtrlWidth+payloadWidth-1:0] cromWord
);

   // Jump field, select fields and call flag, payload
   localparam int wordWidth = addrWidth + useqPkg::cromCtrlWidth + payloadWidth;
   localparam int romDepth = 2 ** addrWidth;
   localparam string romFile = "hw/microcode.hex";

   logic [wordWidth-1:0] romMem [romDepth];

   //////////////////////////////
   // Microcode image
   //////////////////////////////

   // Unlisted words read as zero and jump to 0 with no action
   initial
   begin
      for (int i = 0; i < romDepth; i++)
      begin
         romMem[i] = '0;
      end
      $readmemh(romFile, romMem);
   end

   //////////////////////////////
   // Output register
   //////////////////////////////

   // Cleared word means no call, no dispatch, no skip
   // Loads one cycle after the address is presented
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         cromWord <= '0;
      else if (clken)
         cromWord <= romMem[nextAddr];
   end

endmodule

// ==== hw/dispatchMux.sv ====
`timescale 1ns/10ps

module dispatchMux
(
   input  useqPkg::cromWordT  cromWord,
   input  useqPkg::uAddrT     diagAddr,
   input  useqPkg::uAddrT     topAddr,
   input  useqPkg::dispFieldT dispByte,
   input  useqPkg::dispFieldT dispEa,
   input  useqPkg::dispFieldT dispNorm,
   input  logic [7:1]         skipCond,
   input  useqPkg::dispFieldT acField,
   input  useqPkg::dromWordT  dromWord,
   output useqPkg::uAddrT     dispAddr,
   output useqPkg::uAddrT     skipAddr,
   output logic               isReturn
);

   logic [useqPkg::dispSelWidth-1:0] dispRaw;
   useqPkg::dispSelT dispSel;
   useqPkg::skipSelT skipSel;
   logic [7:0] condVec;
   logic dromAeqj;
   logic dromAcDisp;
   useqPkg::uAddrT dromJ;
   useqPkg::dispFieldT dromA;
   useqPkg::uAddrT areadAddr;

   //////////////////////////////
   // Field extraction
   //////////////////////////////

   assign dispRaw = cromWord[useqPkg::cromDispLsb +: useqPkg::dispSelWidth];
   assign dispSel = useqPkg::dispSelT'(dispRaw);
   assign skipSel = useqPkg::skipSelT'(cromWord[useqPkg::cromSkipLsb +: useqPkg::skipSelWidth]);

   assign dromAeqj = dromWord[useqPkg::dromAeqjBit];
   assign dromAcDisp = dromWord[useqPkg::dromAcDispBit];
   assign dromJ = dromWord[useqPkg::dromJLsb +: useqPkg::addrWidth];
   assign dromA = dromWord[useqPkg::dromALsb +: useqPkg::dispFieldWidth];

   // AREAD target
   always_comb
   begin
      if (!dromAeqj)
         // Memory operand setup, dispatch on A
         areadAddr = useqPkg::areadBase | useqPkg::uAddrT'(dromA);
      else if (dromAcDisp)
         // AC field expands the opcode to 16 entries
         areadAddr = {dromJ[useqPkg::addrWidth-1:useqPkg::dispFieldWidth], acField};
      else
         // No setup needed, straight to J
         areadAddr = dromJ;
   end

   // Dispatch select
   always_comb
   begin
      case (dispSel)
         useqPkg::dispNone:   dispAddr = '0;
         useqPkg::dispDiag:   dispAddr = diagAddr;
         useqPkg::dispReturn: dispAddr = topAddr;
         useqPkg::dispAread:  dispAddr = areadAddr;
         useqPkg::dispByte:   dispAddr = useqPkg::uAddrT'(dispByte);
         useqPkg::dispEa:     dispAddr = useqPkg::uAddrT'(dispEa);
         useqPkg::dispNorm:   dispAddr = useqPkg::uAddrT'(dispNorm);
         default:             dispAddr = '0;
      endcase
   end

   // Bit 0 stands in for skipNone so it never skips
   assign condVec = {skipCond, 1'b0};
   assign skipAddr = useqPkg::uAddrT'(condVec[skipSel]);

   assign isReturn = (dispSel == useqPkg::dispReturn);

   // Microcode must only use the defined dispatch kinds
   always_comb
   begin
      assert (dispRaw <= useqPkg::dispNorm)
         else $error("dispatchMux: undefined dispatch select %0d", dispRaw);
   end

endmodule

// ==== hw/microSequencer.sv ====
`timescale 1ns/10ps

module microSequencer
(
   input  logic              clk,
   input  logic              rst,
   input  logic              clken,
   input  logic              pageFail,
   input  useqPkg::cromWordT cromWord,
   input  useqPkg::uAddrT    dispAddr,
   input  useqPkg::uAddrT    skipAddr,
   input  logic              isReturn,
   output useqPkg::uAddrT    nextAddr,
   output logic              push,
   output logic              pop
);

   logic resetHold;
   useqPkg::uAddrT jumpAddr;
   logic callFlag;

   //////////////////////////////
   // Reset hold
   //////////////////////////////

   // The ROM output register is cleared by rst, so nothing
   // has been fetched yet
   // Hold the address at zero until the first enabled edge
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         resetHold <= 1'b1;
      else if (clken)
         resetHold <= 1'b0;
   end

   //////////////////////////////
   // Next address
   //////////////////////////////

   assign jumpAddr = cromWord[useqPkg::cromJumpLsb +: useqPkg::addrWidth];
   assign callFlag = cromWord[useqPkg::cromCallBit];

   // Reset first, then page fail, then the OR of J, dispatch and skip
   always_comb
   begin
      if (resetHold)
         nextAddr = useqPkg::resetAddr;
      else if (pageFail)
         // Trap handler sits at the top of the store
         nextAddr = useqPkg::trapAddr;
      else
         // Microcode leaves the dispatched bits of J clear
         nextAddr = jumpAddr | dispAddr | skipAddr;
   end

   //////////////////////////////
   // Call and return
   //////////////////////////////

   // Page fail pushes the trap address like a call
   assign push = callFlag | pageFail;
   // Return dispatch takes the stack top
   assign pop = isReturn;

   //////////////////////////////
   // Checks
   //////////////////////////////

   // No call or dispatch can be live before the first fetch
   property pResetFetch;
      @(posedge clk) disable iff (rst)
         resetHold |-> cromWord == '0;
   endproperty

   aResetFetch: assert property (pResetFetch)
      else $error("microSequencer: microword not cleared during reset hold");

endmodule

// ==== hw/microcode.hex ====
// jump[32:24] dispSel[23:20] skipSel,call[19:16] payload[15:0]
001005A00
002005A01
003005A02
004005A03
010505A04
000005A05
000005A06
000005A07
000005A08
000005A09
000005A0A
000005A0B
000005A0C
000005A0D
000005A0E
000005A0F
000005A10
000005A11
000005A12
000005A13
01C015A14
000105A15
000305A16
000005A17
01A065A18
000005A19
018005A1A
014015A1B
001205A1C
001205A1D
000005A1E
000005A1F

// ==== hw/returnStack.sv ====
`timescale 1ns/10ps

module returnStack
#(
   parameter int addrWidth = useqPkg::addrWidth,
   parameter int stackDepth = 8
)
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 clken,
   input  logic                 push,
   input  logic                 pop,
   input  logic [addrWidth-1:0] pushAddr,
   output logic [addrWidth-1:0] topAddr
);

   // Count needs one more value than the depth
   localparam int ptrWidth = $clog2(stackDepth + 1);
   localparam int idxWidth = $clog2(stackDepth);

   logic [addrWidth-1:0] stackMem [stackDepth];
   logic [ptrWidth-1:0] depth;
   logic [idxWidth-1:0] topIdx;
   logic [idxWidth-1:0] freeIdx;
   logic full;
   logic empty;

   assign empty = (depth == '0);
   assign full = (depth == ptrWidth'(stackDepth));

   // Top is one below the count, free slot is at the count
   assign topIdx = idxWidth'(depth - 1'b1);
   assign freeIdx = idxWidth'(depth);
   assign topAddr = stackMem[topIdx];

   //////////////////////////////
   // Entries
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (clken && push)
      begin
         // Push with pop overwrites the top in place
         if (pop)
            stackMem[topIdx] <= pushAddr;
         else
            stackMem[freeIdx] <= pushAddr;
      end
   end

   // Entry count
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         depth <= '0;
      else if (clken)
      begin
         if (push && !pop)
            depth <= depth + 1'b1;
         else if (pop && !push)
            depth <= depth - 1'b1;
      end
   end

   //////////////////////////////
   // Checks
   //////////////////////////////

   aNoOverflow: assert property (@(posedge clk) disable iff (rst)
      (clken && push && !pop) |-> !full)
      else $error("returnStack: push on a full stack");

   aNoUnderflow: assert property (@(posedge clk) disable iff (rst)
      (clken && pop) |-> !empty)
      else $error("returnStack: return with an empty stack");

endmodule

// ==== hw/useqPkg.sv ====
package useqPkg;

   //////////////////////////////
   // Default widths
   //////////////////////////////

   // Microaddress, 512 words of control store
   localparam int addrWidth = 9;
   // Control field handed on to the datapath
   localparam int payloadWidth = 16;

   // Select fields of the microword
   localparam int dispSelWidth = 4;
   localparam int skipSelWidth = 3;
   // Dispatch nibbles and the IR AC field
   localparam int dispFieldWidth = 4;
   // Dispatch select, skip select and call flag together
   localparam int cromCtrlWidth = dispSelWidth + skipSelWidth + 1;
   localparam int cromWidth = addrWidth + cromCtrlWidth + payloadWidth;

   //////////////////////////////
   // Microword layout
   //////////////////////////////

   // Payload in the low bits, jump field at the top
   localparam int cromPayloadLsb = 0;
   localparam int cromCallBit = cromPayloadLsb + payloadWidth;
   localparam int cromSkipLsb = cromCallBit + 1;
   localparam int cromDispLsb = cromSkipLsb + skipSelWidth;
   localparam int cromJumpLsb = cromDispLsb + dispSelWidth;

   // Dispatch ROM word, A field lowest, A-equals-J flag highest
   localparam int dromALsb = 0;
   localparam int dromJLsb = dromALsb + dispFieldWidth;
   localparam int dromAcDispBit = dromJLsb + addrWidth;
   localparam int dromAeqjBit = dromAcDispBit + 1;
   localparam int dromWidth = dromAeqjBit + 1;

   //////////////////////////////
   // Types
   //////////////////////////////

   typedef logic [addrWidth-1:0] uAddrT;
   typedef logic [dispFieldWidth-1:0] dispFieldT;
   typedef logic [payloadWidth-1:0] payloadT;
   typedef logic [cromWidth-1:0] cromWordT;
   typedef logic [dromWidth-1:0] dromWordT;

   // Dispatch kinds, encodings above dispNorm are unused
   typedef enum logic [dispSelWidth-1:0] {
      dispNone,
      dispDiag,
      dispReturn,
      dispAread,
      dispByte,
      dispEa,
      dispNorm
   } dispSelT;

   // Skip kinds, the value picks the skipCond bit
   typedef enum logic [skipSelWidth-1:0] {
      skipNone,
      skipCond1,
      skipCond2,
      skipCond3,
      skipCond4,
      skipCond5,
      skipCond6,
      skipCond7
   } skipSelT;

   // Forced addresses
   localparam uAddrT resetAddr = '0;
   localparam uAddrT trapAddr = '1;
   // AREAD on the A field lands in octal 40 to 57
   localparam uAddrT areadBase = 9'o040;

endpackage

// ==== hw/useqTop.sv ====
`timescale 1ns/10ps

module useqTop
#(
   parameter int addrWidth = useqPkg::addrWidth,
   parameter int payloadWidth = useqPkg::payloadWidth
)
(
   input  logic               clk,
   input  logic               rst,
   input  logic               clken,
   input  logic               pageFail,
   input  useqPkg::uAddrT     diagAddr,
   input  useqPkg::dispFieldT dispByte,
   input  useqPkg::dispFieldT dispEa,
   input  useqPkg::dispFieldT dispNorm,
   input  logic [7:1]         skipCond,
   input  useqPkg::dispFieldT acField,
   input  useqPkg::dromWordT  dromWord,
   output useqPkg::cromWordT  cromWord,
   output useqPkg::uAddrT     microAddr
);

   useqPkg::uAddrT dispAddr;
   useqPkg::uAddrT skipAddr;
   useqPkg::uAddrT topAddr;
   logic isReturn;
   logic push;
   logic pop;

   //////////////////////////////
   // Address formation
   //////////////////////////////

   dispatchMux dispMux0
   (
      .cromWord (cromWord),
      .diagAddr (diagAddr),
      .topAddr  (topAddr),
      .dispByte (dispByte),
      .dispEa   (dispEa),
      .dispNorm (dispNorm),
      .skipCond (skipCond),
      .acField  (acField),
      .dromWord (dromWord),
      .dispAddr (dispAddr),
      .skipAddr (skipAddr),
      .isReturn (isReturn)
   );

   // Fetch address doubles as the trace output
   microSequencer useq0
   (
      .clk      (clk),
      .rst      (rst),
      .clken    (clken),
      .pageFail (pageFail),
      .cromWord (cromWord),
      .dispAddr (dispAddr),
      .skipAddr (skipAddr),
      .isReturn (isReturn),
      .nextAddr (microAddr),
      .push     (push),
      .pop      (pop)
   );

   //////////////////////////////
   // Stack and store
   //////////////////////////////

   returnStack #(.addrWidth(addrWidth)) stack0
   (
      .clk      (clk),
      .rst      (rst),
      .clken    (clken),
      .push     (push),
      .pop      (pop),
      .pushAddr (microAddr),
      .topAddr  (topAddr)
   );

   controlStore #(.addrWidth(addrWidth), .payloadWidth(payloadWidth)) crom0
   (
      .clk      (clk),
      .rst      (rst),
      .clken    (clken),
      .nextAddr (microAddr),
      .cromWord (cromWord)
   );

endmodule

// ==== microseq.f ====
hw/useqPkg.sv
hw/dispatchMux.sv
hw/microSequencer.sv
hw/returnStack.sv
hw/controlStore.sv
hw/useqTop.sv
verification/useqTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the microsequencer testbench with Verilator

cd "$(dirname "$0")" || exit 1

logFile=sim.log
buildDir=obj_dir
simBin=useqSim

verilator --binary --timing --assert -Wno-fatal \
   -f microseq.f \
   --top-module useqTb \
   --Mdir "$buildDir" \
   -o "$simBin"
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

"./$buildDir/$simBin" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
   echo "Simulation exited with status $simStatus"
   exit 1
fi

if grep -q "Test completed successfully" "$logFile"; then
   echo "PASS"
   exit 0
else
   echo "FAIL"
   exit 1
fi

// ==== verification/useqTb.sv ====
`timescale 1ns/10ps

module useqTb;

   localparam int clkPeriod = 20;
   localparam int driveDelay = 2;
   // Mid-cycle sample, well clear of both edges
   localparam int sampleDelay = 8;
   localparam int numRows = 31;
   localparam int watchdogTime = (numRows + 50) * clkPeriod;

   // Input that carries the row value
   localparam int routeNone = 0;
   localparam int routeByte = 1;
   localparam int routeEa = 2;
   localparam int routeNorm = 3;
   localparam int routeDiag = 4;
   localparam int routeSkip = 5;

   logic clk;
   logic rst;
   logic clken;
   logic pageFail;
   useqPkg::uAddrT diagAddr;
   useqPkg::dispFieldT dispByte;
   useqPkg::dispFieldT dispEa;
   useqPkg::dispFieldT dispNorm;
   logic [7:1] skipCond;
   useqPkg::dispFieldT acField;
   useqPkg::dromWordT dromWord;
   useqPkg::cromWordT cromWord;
   useqPkg::uAddrT microAddr;

   //////////////////////////////
   // Stimulus table
   //////////////////////////////

   logic rowClken [numRows];
   logic rowPageFail [numRows];
   int rowRoute [numRows];
   useqPkg::uAddrT rowValue [numRows];
   useqPkg::dispFieldT rowAc [numRows];
   useqPkg::dromWordT rowDrom [numRows];
   useqPkg::uAddrT rowExpAddr [numRows];

   int rowCount;
   int seed;
   int addrErrors;
   int payloadErrors;
   // Payload the output register should hold right now
   useqPkg::payloadT heldPayload;

   useqTop #(.addrWidth(useqPkg::addrWidth), .payloadWidth(useqPkg::payloadWidth)) dut0
   (
      .clk       (clk),
      .rst       (rst),
      .clken     (clken),
      .pageFail  (pageFail),
      .diagAddr  (diagAddr),
      .dispByte  (dispByte),
      .dispEa    (dispEa),
      .dispNorm  (dispNorm),
      .skipCond  (skipCond),
      .acField   (acField),
      .dromWord  (dromWord),
      .cromWord  (cromWord),
      .microAddr (microAddr)
   );

   // A-equals-J, AC dispatch, J, A from top to bottom
   function automatic useqPkg::dromWordT packDrom(input logic aeqj, input logic acDisp,
                                                  input useqPkg::uAddrT j,
                                                  input useqPkg::dispFieldT a);
      return {aeqj, acDisp, j, a};
   endfunction

   // Words 0 to 31 carry 5A in the high byte and their address below
   function automatic useqPkg::payloadT expectedPayload(input useqPkg::uAddrT addr);
      if (addr < 9'd32)
         return 16'h5A00 | {7'b0, addr};
      else
         return '0;
   endfunction

   task automatic addRow(input logic en, input logic pf, input int route,
                         input useqPkg::uAddrT value, input useqPkg::dispFieldT ac,
                         input useqPkg::dromWordT drom, input useqPkg::uAddrT expAddr);
      rowClken[rowCount] = en;
      rowPageFail[rowCount] = pf;
      rowRoute[rowCount] = route;
      rowValue[rowCount] = value;
      rowAc[rowCount] = ac;
      rowDrom[rowCount] = drom;
      rowExpAddr[rowCount] = expAddr;
      rowCount++;
   endtask

   task automatic buildTable();
      rowCount = 0;
      // Reset hold, then the straight chain 0 to 4
      addRow(1, 0, routeNone, 9'h000, 4'h0, 15'h0000, 9'h000);
      addRow(1, 0, routeNone, 9'h000, 4'h0, 15'h0000, 9'h001);
      addRow(1, 0, routeNone, 9'h000, 4'h0, 15'h0000, 9'h002);
      addRow(1, 0, routeNone, 9'h000, 4'h0, 15'h0000, 9'h003);
      addRow(1, 0, routeNone, 9'h000, 4'h0, 15'h0000, 9'h004);
      // EA dispatch, J 0x10 OR nibble 6
      addRow(1, 0, routeEa, 9'h006, 4'h0, 15'h0000, 9'h016);
      // AREAD held, A onto octal 40, then plain J
      addRow(0, 0, routeNone, 9'h000, 4'h5, packDrom(1'b0, 1'b0, 9'h1FF, 4'h7), 9'h027);
      addRow(0, 0, routeNone, 9'h000, 4'h5, packDrom(1'b1, 1'b0, 9'h0C3, 4'hF), 9'h0C3);
      // AC field replaces the low J bits
      addRow(1, 0, routeNone, 9'h000, 4'h8, packDrom(1'b1, 1'b1, 9'h01F, 4'h0), 9'h018);
      // Skip loop on condition 3, false then true
      addRow(1, 0, routeSkip, 9'h000, 4'h0, 15'h0000, 9'h01A);
      addRow(1, 0, routeNone, 9'h000, 4'h0, 15'h0000, 9'h018);
      addRow(1, 0, routeSkip, 9'h001, 4'h0, 15'h0000, 9'h01B);
      // Call to 20, nested call to 28
      addRow(1, 0, routeNone, 9'h000, 4'h0, 15'h0000, 9'h014);
      addRow(1, 0, routeNone, 9'h000, 4'h0, 15'h0000, 9'h01C);
      // Two returns, saved address OR J of 1
      addRow(1, 0, routeNone, 9'h000, 4'h0, 15'h0000, 9'h01D);
      addRow(1, 0, routeNone, 9'h000, 4'h0, 15'h0000, 9'h015);
      // Diagnostic jump to 30
      addRow(1, 0, routeDiag, 9'h01E, 4'h0, 15'h0000, 9'h01E);
      // Page fail traps and pushes the trap address
      addRow(1, 1, routeNone, 9'h000, 4'h0, 15'h0000, 9'h1FF);
      addRow(1, 0, routeNone, 9'h000, 4'h0, 15'h0000, 9'h000);
      addRow(1, 0, routeNone, 9'h000, 4'h0, 15'h0000, 9'h001);
      addRow(1, 0, routeNone, 9'h000, 4'h0, 15'h0000, 9'h002);
      addRow(1, 0, routeNone, 9'h000, 4'h0, 15'h0000, 9'h003);
      addRow(1, 0, routeNone, 9'h000, 4'h0, 15'h0000, 9'h004);
      // EA nibble C into the return word
      addRow(1, 0, routeEa, 9'h00C, 4'h0, 15'h0000, 9'h01C);
      addRow(1, 0, routeNone, 9'h000, 4'h0, 15'h0000, 9'h1FF);
      addRow(1, 0, routeNone, 9'h000, 4'h0, 15'h0000, 9'h000);
      // Clock enable low, everything holds on word 0
      addRow(0, 0, routeNone, 9'h000, 4'h0, 15'h0000, 9'h001);
      addRow(0, 0, routeNone, 9'h000, 4'h0, 15'h0000, 9'h001);
      addRow(0, 0, routeNone, 9'h000, 4'h0, 15'h0000, 9'h001);
      addRow(1, 0, routeNone, 9'h000, 4'h0, 15'h0000, 9'h001);
      addRow(1, 0, routeNone, 9'h000, 4'h0, 15'h0000, 9'h002);
   endtask

   // Unselected dispatch inputs get random filler
   task automatic applyRow(input int idx);
      logic [31:0] fill;
      fill = $random(seed);
      clken = rowClken[idx];
      pageFail = rowPageFail[idx];
      acField = rowAc[idx];
      dromWord = rowDrom[idx];
      dispByte = fill[3:0];
      dispEa = fill[7:4];
      dispNorm = fill[11:8];
      skipCond = fill[18:12];
      diagAddr = fill[27:19];
      case (rowRoute[idx])
         routeByte: dispByte = rowValue[idx][3:0];
         routeEa:   dispEa = rowValue[idx][3:0];
         routeNorm: dispNorm = rowValue[idx][3:0];
         routeDiag: diagAddr = rowValue[idx];
         routeSkip: skipCond[3] = rowValue[idx][0];
         default:   ;
      endcase
   endtask

   task automatic checkAddr(input string name, input useqPkg::uAddrT actual,
                            input useqPkg::uAddrT expected);
      if (actual !== expected)
      begin
         addrErrors++;
         $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      end
   endtask

   task automatic checkPayload(input string name, input useqPkg::payloadT actual,
                               input useqPkg::payloadT expected);
      if (actual !== expected)
      begin
         payloadErrors++;
         $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      end
   endtask

   //////////////////////////////
   // Clock and watchdog
   //////////////////////////////

   initial
   begin
      clk = 1'b0;
      forever #(clkPeriod / 2) clk = ~clk;
   end

   initial
   begin
      #(watchdogTime);
      $display("Watchdog expired before the stimulus table finished");
      $display("Test failed");
      $finish;
   end

   //////////////////////////////
   // Stimulus and checks
   //////////////////////////////

   initial
   begin
      seed = 94454;
      addrErrors = 0;
      payloadErrors = 0;
      rst = 1'b1;
      clken = 1'b0;
      pageFail = 1'b0;
      diagAddr = '0;
      dispByte = '0;
      dispEa = '0;
      dispNorm = '0;
      skipCond = '0;
      acField = '0;
      dromWord = '0;
      heldPayload = '0;
      buildTable();
      repeat (3) @(posedge clk);
      #(driveDelay);
      rst = 1'b0;
      for (int i = 0; i < numRows; i++)
      begin
         applyRow(i);
         #(sampleDelay);
         checkAddr($sformatf("microAddr row %0d", i), microAddr, rowExpAddr[i]);
         checkPayload($sformatf("cromWord payload row %0d", i),
                      cromWord[useqPkg::cromPayloadLsb +: useqPkg::payloadWidth], heldPayload);
         // Enabled edge loads the word at the presented address
         if (rowClken[i])
            heldPayload = expectedPayload(rowExpAddr[i]);
         @(posedge clk);
         #(driveDelay);
      end
      $display("Checks done: %0d address errors, %0d payload errors", addrErrors, payloadErrors);
      if (addrErrors == 0 && payloadErrors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule
